// File: rtl/ddr_test_pkg.sv
package ddr_test_pkg;

   // ------------------------------
   // widths
   // ------------------------------

   // controller user port word address
   localparam int ddr_addr_w = 22;
   // one mask bit per data byte
   localparam int ddr_mask_w = 8;
   // longest burst the sequencer issues
   localparam int burst_max = 16;
   localparam int burst_cnt_w = $clog2(burst_max);

   typedef logic [63:0] ddr_word_t;
   typedef logic [5:0] host_addr_t;
   typedef logic [31:0] host_data_t;

   // ------------------------------
   // enums
   // ------------------------------

   // user command encoding of the controller
   typedef enum logic [3:0] {
      cmd_nop   = 4'b0000,
      cmd_init  = 4'b0010,
      cmd_write = 4'b0100,
      cmd_read  = 4'b0110
   } ddr_cmd_e;

   typedef enum logic {
      pat_addr = 1'b0,
      pat_seed = 1'b1
   } pattern_e;

   typedef enum logic [3:0] {
      idle,
      wait_init,
      wr_burst,
      wr_end,
      rd_burst,
      rd_end,
      wait_ref,
      wait_data,
      done_st
   } seq_state_e;

   // ------------------------------
   // register map, word addresses
   // ------------------------------

   localparam host_addr_t reg_ctrl      = 6'h00;
   localparam host_addr_t reg_base      = 6'h01;
   localparam host_addr_t reg_len       = 6'h02;
   localparam host_addr_t reg_seed      = 6'h03;
   localparam host_addr_t reg_status    = 6'h04;
   localparam host_addr_t reg_err_count = 6'h05;
   localparam host_addr_t reg_err_addr  = 6'h06;

   // expected memory word for one address
   // addr mode: address on top, its complement below
   // seed mode: seed xor address on top, seed plus address below
   function automatic ddr_word_t pattern_word(
      input pattern_e mode,
      input host_data_t seed,
      input logic [ddr_addr_w-1:0] addr
   );
      host_data_t addr_ext;
      addr_ext = host_data_t'(addr);
      if (mode == pat_seed) begin
         return {seed ^ addr_ext, seed + addr_ext};
      end
      return {addr_ext, ~addr_ext};
   endfunction

endpackage

// File: rtl/ddr_test_regs.sv
`timescale 1ns/1ps

module ddr_test_regs
   import ddr_test_pkg::*;
(
   input  logic                  core_clk,
   input  logic                  arst_n,
   // host bus
   input  logic                  cpci_req,
   input  logic                  cpci_rd_wr_l,
   input  host_addr_t            cpci_addr,
   input  host_data_t            cpci_wr_data,
   output host_data_t            cpci_rd_data,
   output logic                  cpci_wr_rdy,
   output logic                  cpci_rd_rdy,
   // status sources
   input  logic                  busy,
   input  logic                  done,
   input  logic                  ddr2_init_val,
   input  host_data_t            err_count,
   input  logic [ddr_addr_w-1:0] err_addr,
   // test configuration
   output logic                  start,
   output pattern_e              mode,
   output logic [ddr_addr_w-1:0] base,
   output logic [ddr_addr_w-1:0] len,
   output host_data_t            seed
);

   logic       wr_en;
   logic       rd_en;
   logic       cfg_wr;
   host_data_t rd_mux;

   // high cpci_rd_wr_l selects a read
   assign wr_en = cpci_req && !cpci_rd_wr_l;
   assign rd_en = cpci_req && cpci_rd_wr_l;
   // config is frozen while a test runs, so base/len/mode/seed stay fixed
   assign cfg_wr = wr_en && !busy;

   // ------------------------------
   // writable registers
   // ------------------------------
   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         cpci_wr_rdy <= 1'b0;
         cpci_rd_rdy <= 1'b0;
         start <= 1'b0;
         mode <= pat_addr;
         base <= '0;
         len <= '0;
         seed <= '0;
      end else begin
         // answer exactly one cycle after the request
         cpci_wr_rdy <= wr_en;
         cpci_rd_rdy <= rd_en;
         // bit 0 of ctrl is a self-clearing start
         start <= cfg_wr && (cpci_addr == reg_ctrl) && cpci_wr_data[0];
         if (cfg_wr) begin
            case (cpci_addr)
               reg_ctrl: mode <= pattern_e'(cpci_wr_data[1]);
               reg_base: base <= cpci_wr_data[ddr_addr_w-1:0];
               reg_len:  len <= cpci_wr_data[ddr_addr_w-1:0];
               reg_seed: seed <= cpci_wr_data;
               default: ;
            endcase
         end
      end
   end

   // ------------------------------
   // read multiplexer
   // ------------------------------
   always_comb begin
      case (cpci_addr)
         reg_ctrl:      rd_mux = {30'b0, mode, 1'b0};
         reg_base:      rd_mux = host_data_t'(base);
         reg_len:       rd_mux = host_data_t'(len);
         reg_seed:      rd_mux = seed;
         reg_status:    rd_mux = {29'b0, ddr2_init_val, done, busy};
         reg_err_count: rd_mux = err_count;
         reg_err_addr:  rd_mux = host_data_t'(err_addr);
         // unmapped reads back as zero
         default:       rd_mux = '0;
      endcase
   end

   // read data lines up with cpci_rd_rdy
   always_ff @(posedge core_clk) begin
      if (rd_en) begin
         cpci_rd_data <= rd_mux;
      end
   end

endmodule

// File: rtl/ddr_block_rw.sv
`timescale 1ns/1ps

module ddr_block_rw
   import ddr_test_pkg::*;
(
   input  logic                  core_clk,
   input  logic                  arst_n,
   // test configuration
   input  logic                  start,
   input  logic [ddr_addr_w-1:0] base,
   input  logic [ddr_addr_w-1:0] len,
   input  pattern_e              mode,
   input  host_data_t            seed,
   // controller user port
   input  logic                  ddr2_init_val,
   input  logic                  ddr2_cmd_ack,
   input  logic                  ddr2_auto_ref_req,
   input  logic                  ddr2_ar_done,
   output ddr_cmd_e              ddr2_cmd,
   output logic [ddr_addr_w-1:0] ddr2_addr,
   output ddr_word_t             ddr2_wr_data,
   output logic                  ddr2_burst_done,
   // checker handshake
   input  logic                  read_complete,
   output logic                  chk_clear,
   // status
   output logic                  busy,
   output logic                  done
);

   seq_state_e             state;
   logic [ddr_addr_w-1:0]  cur_addr;
   // words still to move in the current phase
   logic [ddr_addr_w-1:0]  remaining;
   logic [burst_cnt_w-1:0] burst_cnt;
   logic                   rd_phase;
   // checker may finish before we reach wait_data
   logic                   rd_seen;
   logic                   accept;
   logic                   last_word;

   assign busy = (state != idle) && (state != done_st);
   assign done = state == done_st;

   // a start while busy is dropped
   assign accept = start && !busy;
   assign chk_clear = accept;

   // word in flight closes the burst on max length or end of block
   assign last_word = (burst_cnt == burst_cnt_w'(burst_max - 1)) ||
                      (remaining == ddr_addr_w'(1));

   // ------------------------------
   // user port outputs
   // ------------------------------
   // command, address and data hold while ack is low
   always_comb begin
      case (state)
         wr_burst: ddr2_cmd = cmd_write;
         rd_burst: ddr2_cmd = cmd_read;
         default:  ddr2_cmd = cmd_nop;
      endcase
   end

   assign ddr2_addr = cur_addr;
   assign ddr2_wr_data = pattern_word(mode, seed, cur_addr);
   // one cycle pulse after the last word of each burst
   assign ddr2_burst_done = (state == wr_end) || (state == rd_end);

   // ------------------------------
   // sequencer
   // ------------------------------
   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= idle;
         cur_addr <= '0;
         remaining <= '0;
         burst_cnt <= '0;
         rd_phase <= 1'b0;
         rd_seen <= 1'b0;
      end else begin
         if (accept) begin
            rd_seen <= 1'b0;
         end else if (read_complete) begin
            rd_seen <= 1'b1;
         end

         case (state)
            idle, done_st: begin
               if (accept) begin
                  cur_addr <= base;
                  remaining <= len;
                  burst_cnt <= '0;
                  rd_phase <= 1'b0;
                  state <= wait_init;
               end
            end

            // nothing goes out before the controller has initialised
            wait_init: begin
               if (ddr2_init_val) begin
                  if (remaining == '0) begin
                     state <= done_st;
                  end else if (ddr2_auto_ref_req) begin
                     state <= wait_ref;
                  end else begin
                     state <= wr_burst;
                  end
               end
            end

            // one word per acked cycle, address follows
            wr_burst, rd_burst: begin
               if (ddr2_cmd_ack) begin
                  cur_addr <= cur_addr + 1'b1;
                  remaining <= remaining - 1'b1;
                  burst_cnt <= burst_cnt + 1'b1;
                  if (last_word) begin
                     state <= rd_phase ? rd_end : wr_end;
                  end
               end
            end

            wr_end: begin
               burst_cnt <= '0;
               if (remaining == '0) begin
                  // whole block written, rewind for the read pass
                  cur_addr <= base;
                  remaining <= len;
                  rd_phase <= 1'b1;
               end
               if (ddr2_auto_ref_req) begin
                  state <= wait_ref;
               end else if (remaining == '0) begin
                  state <= rd_burst;
               end else begin
                  state <= wr_burst;
               end
            end

            rd_end: begin
               burst_cnt <= '0;
               if (remaining == '0) begin
                  state <= wait_data;
               end else if (ddr2_auto_ref_req) begin
                  state <= wait_ref;
               end else begin
                  state <= rd_burst;
               end
            end

            // refresh only between bursts
            wait_ref: begin
               if (ddr2_ar_done) begin
                  state <= rd_phase ? rd_burst : wr_burst;
               end
            end

            // reads still in flight
            wait_data: begin
               if (rd_seen || read_complete) begin
                  state <= done_st;
               end
            end

            default: state <= idle;
         endcase
      end
   end

endmodule

// File: rtl/ddr_read_checker.sv
`timescale 1ns/1ps

module ddr_read_checker
   import ddr_test_pkg::*;
(
   input  logic                  core_clk,
   input  logic                  arst_n,
   input  logic                  chk_clear,
   // test configuration
   input  logic [ddr_addr_w-1:0] base,
   input  logic [ddr_addr_w-1:0] len,
   input  pattern_e              mode,
   input  host_data_t            seed,
   // read return path
   input  logic                  ddr2_rd_data_valid,
   input  ddr_word_t             ddr2_rd_data,
   // results
   output host_data_t            err_count,
   output logic [ddr_addr_w-1:0] err_addr,
   output logic                  read_complete
);

   // words come back in address order
   logic [ddr_addr_w-1:0] exp_addr;
   logic [ddr_addr_w-1:0] rcv_cnt;
   logic                  err_seen;
   ddr_word_t             exp_word;
   logic                  mismatch;

   assign exp_word = pattern_word(mode, seed, exp_addr);
   assign mismatch = ddr2_rd_data != exp_word;

   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         exp_addr <= '0;
         rcv_cnt <= '0;
         err_seen <= 1'b0;
         err_count <= '0;
         err_addr <= '0;
         read_complete <= 1'b0;
      end else begin
         read_complete <= 1'b0;
         if (chk_clear) begin
            exp_addr <= base;
            rcv_cnt <= '0;
            err_seen <= 1'b0;
            err_count <= '0;
            err_addr <= '0;
         end else if (ddr2_rd_data_valid) begin
            exp_addr <= exp_addr + 1'b1;
            rcv_cnt <= rcv_cnt + 1'b1;
            if (mismatch) begin
               err_count <= err_count + 1'b1;
               // keep only the first failing address
               if (!err_seen) begin
                  err_addr <= exp_addr;
                  err_seen <= 1'b1;
               end
            end
            // last expected word of the block
            if (rcv_cnt == len - 1'b1) begin
               read_complete <= 1'b1;
            end
         end
      end
   end

endmodule

// File: rtl/ddr_test_top.sv
`timescale 1ns/1ps

module ddr_test_top
   import ddr_test_pkg::*;
(
   input  logic                  core_clk,
   input  logic                  arst_n,
   // ------------------------------
   // host register bus
   // ------------------------------
   input  logic                  cpci_req,
   input  logic                  cpci_rd_wr_l,
   input  host_addr_t            cpci_addr,
   input  host_data_t            cpci_wr_data,
   output host_data_t            cpci_rd_data,
   output logic                  cpci_wr_rdy,
   output logic                  cpci_rd_rdy,
   // ------------------------------
   // DDR2 controller user port
   // ------------------------------
   output ddr_cmd_e              ddr2_cmd,
   output logic [ddr_addr_w-1:0] ddr2_addr,
   output ddr_word_t             ddr2_wr_data,
   output logic [ddr_mask_w-1:0] ddr2_wr_data_mask,
   output logic                  ddr2_burst_done,
   input  logic                  ddr2_cmd_ack,
   input  ddr_word_t             ddr2_rd_data,
   input  logic                  ddr2_rd_data_valid,
   input  logic                  ddr2_auto_ref_req,
   input  logic                  ddr2_ar_done,
   input  logic                  ddr2_init_val
);

   logic                  start;
   pattern_e              mode;
   logic [ddr_addr_w-1:0] base;
   logic [ddr_addr_w-1:0] len;
   host_data_t            seed;
   logic                  busy;
   logic                  done;
   logic                  chk_clear;
   logic                  read_complete;
   host_data_t            err_count;
   logic [ddr_addr_w-1:0] err_addr;

   // full words only, every byte written
   assign ddr2_wr_data_mask = '0;

   ddr_test_regs ddr_test_regs_i (
      .core_clk      (core_clk),
      .arst_n        (arst_n),
      .cpci_req      (cpci_req),
      .cpci_rd_wr_l  (cpci_rd_wr_l),
      .cpci_addr     (cpci_addr),
      .cpci_wr_data  (cpci_wr_data),
      .cpci_rd_data  (cpci_rd_data),
      .cpci_wr_rdy   (cpci_wr_rdy),
      .cpci_rd_rdy   (cpci_rd_rdy),
      .busy          (busy),
      .done          (done),
      .ddr2_init_val (ddr2_init_val),
      .err_count     (err_count),
      .err_addr      (err_addr),
      .start         (start),
      .mode          (mode),
      .base          (base),
      .len           (len),
      .seed          (seed)
   );

   ddr_block_rw ddr_block_rw_i (
      .core_clk          (core_clk),
      .arst_n            (arst_n),
      .start             (start),
      .base              (base),
      .len               (len),
      .mode              (mode),
      .seed              (seed),
      .ddr2_init_val     (ddr2_init_val),
      .ddr2_cmd_ack      (ddr2_cmd_ack),
      .ddr2_auto_ref_req (ddr2_auto_ref_req),
      .ddr2_ar_done      (ddr2_ar_done),
      .ddr2_cmd          (ddr2_cmd),
      .ddr2_addr         (ddr2_addr),
      .ddr2_wr_data      (ddr2_wr_data),
      .ddr2_burst_done   (ddr2_burst_done),
      .read_complete     (read_complete),
      .chk_clear         (chk_clear),
      .busy              (busy),
      .done              (done)
   );

   // checks the read pass against the same pattern
   ddr_read_checker ddr_read_checker_i (
      .core_clk           (core_clk),
      .arst_n             (arst_n),
      .chk_clear          (chk_clear),
      .base               (base),
      .len                (len),
      .mode               (mode),
      .seed               (seed),
      .ddr2_rd_data_valid (ddr2_rd_data_valid),
      .ddr2_rd_data       (ddr2_rd_data),
      .err_count          (err_count),
      .err_addr           (err_addr),
      .read_complete      (read_complete)
   );

endmodule

// File: test/ddr_ctrl_model.sv
`timescale 1ns/1ps

module ddr_ctrl_model
   import ddr_test_pkg::*;
(
   input  logic                  core_clk,
   input  logic                  arst_n,
   // user port, driven by the DUT
   input  ddr_cmd_e              ddr2_cmd,
   input  logic [ddr_addr_w-1:0] ddr2_addr,
   input  ddr_word_t             ddr2_wr_data,
   input  logic                  ddr2_burst_done,
   output logic                  ddr2_cmd_ack,
   output ddr_word_t             ddr2_rd_data,
   output logic                  ddr2_rd_data_valid,
   output logic                  ddr2_auto_ref_req,
   output logic                  ddr2_ar_done,
   output logic                  ddr2_init_val,
   // testbench controls
   input  int                    rng_seed,
   input  logic                  init_en,
   input  int                    ref_period,
   input  logic                  fault_en,
   input  logic [ddr_addr_w-1:0] fault_addr,
   input  int                    fault_bit,
   output logic                  violation,
   output int                    max_burst
);

   // sparse memory, only written words exist
   ddr_word_t             mem [logic [ddr_addr_w-1:0]];
   // read words in flight and the cycle each one is due
   ddr_word_t             rd_q [$];
   longint                due_q [$];
   longint                cycle;
   longint                due;
   longint                lat;
   int                    ack_wait;
   int                    ref_wait;
   int                    ref_left;
   int                    burst_words;
   logic                  stalled;
   ddr_cmd_e              stall_cmd;
   logic [ddr_addr_w-1:0] stall_addr;
   ddr_word_t             word;
   // values applied after the next rising edge
   logic                  nx_ack;
   logic                  nx_valid;
   logic                  nx_req;
   logic                  nx_ar;
   ddr_word_t             nx_data;

   function automatic ddr_word_t peek_word(input logic [ddr_addr_w-1:0] addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return '0;
   endfunction

   initial begin
      ddr2_cmd_ack = 1'b0;
      ddr2_rd_data = '0;
      ddr2_rd_data_valid = 1'b0;
      ddr2_auto_ref_req = 1'b0;
      ddr2_ar_done = 1'b0;
      ddr2_init_val = 1'b0;
      violation = 1'b0;
      max_burst = 0;
      cycle = 0;
      due = 0;
      ack_wait = 0;
      ref_wait = 0;
      ref_left = 0;
      burst_words = 0;
      stalled = 1'b0;
      stall_cmd = cmd_nop;
      stall_addr = '0;
      @(posedge arst_n);
      void'($urandom(rng_seed));
      forever begin
         // sample the DUT mid cycle, where its outputs are settled
         @(negedge core_clk);
         cycle++;
         nx_ack = ddr2_cmd_ack;
         nx_req = ddr2_auto_ref_req;
         nx_ar = 1'b0;
         nx_valid = 1'b0;
         nx_data = ddr2_rd_data;

         // ------------------------------
         // data transfer, one word per acked cycle
         // ------------------------------
         if (ddr2_cmd_ack && ddr2_cmd == cmd_write) begin
            word = ddr2_wr_data;
            if (fault_en && ddr2_addr == fault_addr) begin
               word[fault_bit] = ~word[fault_bit];
            end
            mem[ddr2_addr] = word;
            burst_words++;
         end else if (ddr2_cmd_ack && ddr2_cmd == cmd_read) begin
            // a later word never overtakes an earlier one
            lat = cycle + longint'($urandom_range(8, 2));
            due = (lat > due) ? lat : due + 1;
            rd_q.push_back(peek_word(ddr2_addr));
            due_q.push_back(due);
            burst_words++;
         end
         if (burst_words > max_burst) begin
            max_burst = burst_words;
         end

         // ack comes after a random wait, drops after burst_done
         if (ddr2_burst_done) begin
            if (burst_words == 0) begin
               violation = 1'b1;
            end
            burst_words = 0;
            nx_ack = 1'b0;
            ack_wait = $urandom_range(3, 0);
         end else if (ddr2_cmd != cmd_nop && !ddr2_cmd_ack && ref_left == 0) begin
            if (ack_wait == 0) begin
               nx_ack = 1'b1;
            end else begin
               ack_wait--;
            end
         end
         // an unacked command must not move
         if (stalled && (ddr2_cmd != stall_cmd || ddr2_addr != stall_addr)) begin
            violation = 1'b1;
         end
         stalled = ddr2_cmd != cmd_nop && !ddr2_cmd_ack;
         stall_cmd = ddr2_cmd;
         stall_addr = ddr2_addr;

         // ------------------------------
         // refresh, runs only with no burst open
         // ------------------------------
         if (ref_left > 0) begin
            if (ddr2_cmd != cmd_nop) begin
               violation = 1'b1;
            end
            ref_left--;
            if (ref_left == 0) begin
               nx_req = 1'b0;
               nx_ar = 1'b1;
               ref_wait = $urandom_range(ref_period, ref_period / 2);
            end
         end else if (ddr2_auto_ref_req) begin
            if (ddr2_cmd == cmd_nop && !ddr2_cmd_ack) begin
               ref_left = 4;
            end
         end else if (ref_period > 0) begin
            if (ref_wait == 0) begin
               nx_req = 1'b1;
            end else begin
               ref_wait--;
            end
         end

         // read return in address order
         if (due_q.size() > 0 && due_q[0] <= cycle) begin
            nx_valid = 1'b1;
            nx_data = rd_q.pop_front();
            void'(due_q.pop_front());
         end

         @(posedge core_clk);
         #1;
         ddr2_cmd_ack = nx_ack;
         ddr2_rd_data_valid = nx_valid;
         ddr2_rd_data = nx_data;
         ddr2_auto_ref_req = nx_req;
         ddr2_ar_done = nx_ar;
         ddr2_init_val = init_en;
      end
   end

endmodule

// File: test/tb_ddr_test_top.sv
`timescale 1ns/1ps

module tb_ddr_test_top
   import ddr_test_pkg::*;
();

   localparam int rand_seed = 1450;
   localparam int len_t2 = 20;
   localparam int len_t3 = 40;
   localparam int len_t4 = 32;
   localparam int len_t5 = 200;
   // about 40 cycles per word plus register traffic
   localparam int timeout_limit = (len_t2 + len_t3 + len_t4 + len_t5) * 40 + 2000;
   localparam host_addr_t cfg_reg [3] = '{reg_base, reg_len, reg_seed};
   localparam host_data_t cfg_val [3] = '{32'h002a_5a5a, 32'h0000_1234, 32'ha5c3_0f96};

   logic                  core_clk;
   logic                  arst_n;
   logic                  cpci_req;
   logic                  cpci_rd_wr_l;
   host_addr_t            cpci_addr;
   host_data_t            cpci_wr_data;
   host_data_t            cpci_rd_data;
   logic                  cpci_wr_rdy;
   logic                  cpci_rd_rdy;
   ddr_cmd_e              ddr2_cmd;
   logic [ddr_addr_w-1:0] ddr2_addr;
   ddr_word_t             ddr2_wr_data;
   logic [ddr_mask_w-1:0] ddr2_wr_data_mask;
   logic                  ddr2_burst_done;
   logic                  ddr2_cmd_ack;
   ddr_word_t             ddr2_rd_data;
   logic                  ddr2_rd_data_valid;
   logic                  ddr2_auto_ref_req;
   logic                  ddr2_ar_done;
   logic                  ddr2_init_val;
   // model controls
   logic                  init_en;
   int                    ref_period;
   logic                  fault_en;
   logic [ddr_addr_w-1:0] fault_addr;
   int                    fault_bit;
   logic                  violation;
   int                    max_burst;
   // bookkeeping
   pattern_e              tb_mode;
   host_data_t            tb_seed;
   string                 test_name;
   int                    test_errs;
   int                    err_total;
   int                    check_cnt;
   int                    test_cnt;
   int                    fail_cnt;
   int                    ref_seen;
   logic                  ref_hold;
   int                    cycle_cnt;
   host_data_t            rdata;
   logic                  cmd_idle;

   ddr_test_top ddr_test_top_i (.*);

   ddr_ctrl_model model_i (
      .rng_seed (rand_seed),
      .*
   );

   initial begin
      core_clk = 1'b0;
      forever #10 core_clk = ~core_clk;
   end

   // ------------------------------
   // reference and compare tasks
   // ------------------------------
   function automatic ddr_word_t ref_pattern(input pattern_e mode, input host_data_t seed,
                                             input logic [ddr_addr_w-1:0] addr);
      host_data_t a;
      host_data_t hi;
      host_data_t lo;
      a = host_data_t'(addr);
      hi = (mode == pat_addr) ? a : seed ^ a;
      lo = (mode == pat_addr) ? ~a : seed + a;
      return {hi, lo};
   endfunction

   task automatic check_word(input string what, input ddr_word_t exp, input ddr_word_t act);
      check_cnt++;
      if (exp !== act) begin
         test_errs++;
         err_total++;
         $display("Fail %s, %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_reg(input string what, input host_data_t exp, input host_data_t act);
      check_cnt++;
      if (exp !== act) begin
         test_errs++;
         err_total++;
         $display("Fail %s, %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic ok);
      check_cnt++;
      if (ok !== 1'b1) begin
         test_errs++;
         err_total++;
         $display("Error in %s: %s did not hold", test_name, what);
      end
   endtask

   // every word put on the bus must follow the pattern
   always @(negedge core_clk) begin
      if (ddr2_cmd == cmd_write && ddr2_cmd_ack) begin
         check_word("write bus", ref_pattern(tb_mode, tb_seed, ddr2_addr), ddr2_wr_data);
      end
      // refresh requested at a burst boundary holds the next command off
      if (ddr2_burst_done && ddr2_auto_ref_req) begin
         ref_hold = 1'b1;
      end else if (ref_hold && ddr2_ar_done) begin
         ref_hold = 1'b0;
         ref_seen++;
      end else if (ref_hold && ddr2_cmd != cmd_nop) begin
         ref_hold = 1'b0;
         check_flag("no command before the refresh ends", 1'b0);
      end
   end

   // ------------------------------
   // host bus and test helpers
   // ------------------------------
   task automatic host_cycle(input logic rd, input host_addr_t addr, input host_data_t wdata,
                             output host_data_t data);
      @(posedge core_clk);
      #1;
      cpci_req = 1'b1;
      cpci_rd_wr_l = rd;
      cpci_addr = addr;
      cpci_wr_data = wdata;
      @(negedge core_clk);
      check_flag("no answer in the request cycle", !(cpci_rd_rdy || cpci_wr_rdy));
      @(posedge core_clk);
      #1;
      cpci_req = 1'b0;
      @(negedge core_clk);
      check_flag("answer one cycle after the request", rd ? cpci_rd_rdy : cpci_wr_rdy);
      data = cpci_rd_data;
      @(negedge core_clk);
      check_flag("answer lasts one cycle", !(cpci_rd_rdy || cpci_wr_rdy));
   endtask

   task automatic host_write(input host_addr_t addr, input host_data_t data);
      host_data_t unused;
      host_cycle(1'b0, addr, data, unused);
   endtask

   task automatic host_read(input host_addr_t addr, output host_data_t data);
      host_cycle(1'b1, addr, '0, data);
   endtask

   task automatic model_setup(input logic init, input int refresh, input logic fault,
                              input logic [ddr_addr_w-1:0] addr, input int bit_idx);
      @(posedge core_clk);
      #1;
      init_en = init;
      ref_period = refresh;
      fault_en = fault;
      fault_addr = addr;
      fault_bit = bit_idx;
   endtask

   task automatic start_block(input logic [ddr_addr_w-1:0] base, input int len,
                              input pattern_e mode, input host_data_t seed);
      tb_mode = mode;
      tb_seed = seed;
      host_write(reg_base, host_data_t'(base));
      host_write(reg_len, host_data_t'(len));
      host_write(reg_seed, seed);
      host_write(reg_ctrl, {30'b0, mode, 1'b1});
   endtask

   // poll status until the done bit is set
   task automatic wait_done();
      host_data_t status;
      do begin
         host_read(reg_status, status);
      end while (!status[1]);
   endtask

   // flip_idx below zero means no injected fault
   task automatic check_results(input logic [ddr_addr_w-1:0] base, input int len,
                                input int flip_idx, input int flip_bit);
      host_data_t data;
      ddr_word_t exp;
      logic [ddr_addr_w-1:0] a;
      wait_done();
      host_read(reg_status, data);
      check_reg("status after the test", 32'h0000_0006, data);
      host_read(reg_err_count, data);
      check_reg("mismatch count", (flip_idx >= 0) ? 32'd1 : 32'd0, data);
      if (flip_idx >= 0) begin
         host_read(reg_err_addr, data);
         check_reg("first mismatch address", host_data_t'(base + ddr_addr_w'(flip_idx)), data);
      end
      for (int i = 0; i < len; i++) begin
         a = base + ddr_addr_w'(i);
         exp = ref_pattern(tb_mode, tb_seed, a);
         if (i == flip_idx) begin
            exp[flip_bit] = ~exp[flip_bit];
         end
         check_word($sformatf("model word %h", a), exp, model_i.peek_word(a));
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      test_cnt++;
      if (test_errs == 0) begin
         $display("test %0d %s: pass", test_cnt, test_name);
      end else begin
         fail_cnt++;
         $display("test %0d %s: failed with %0d errors", test_cnt, test_name, test_errs);
      end
   endtask

   // ------------------------------
   // run limit
   // ------------------------------
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < timeout_limit) begin
         @(posedge core_clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not end within %0d cycles", timeout_limit);
      $display("Done: errors found");
      $finish;
   end

   // ------------------------------
   // tests
   // ------------------------------
   initial begin
      arst_n = 1'b0;
      cpci_req = 1'b0;
      cpci_rd_wr_l = 1'b0;
      cpci_addr = '0;
      cpci_wr_data = '0;
      init_en = 1'b0;
      ref_period = 0;
      fault_en = 1'b0;
      fault_addr = '0;
      fault_bit = 0;
      tb_mode = pat_addr;
      tb_seed = '0;
      test_errs = 0;
      err_total = 0;
      check_cnt = 0;
      test_cnt = 0;
      fail_cnt = 0;
      ref_seen = 0;
      ref_hold = 1'b0;
      repeat (4) @(posedge core_clk);
      #1;
      arst_n = 1'b1;

      begin_test("register access");
      // controller not initialised yet, so status is all zero
      host_read(reg_status, rdata);
      check_reg("status after reset", 32'h0, rdata);
      for (int i = 0; i < 3; i++) begin
         host_write(cfg_reg[i], cfg_val[i]);
         host_read(cfg_reg[i], rdata);
         check_reg($sformatf("readback of register %0h", cfg_reg[i]), cfg_val[i], rdata);
      end
      host_read(6'h3f, rdata);
      check_reg("unmapped read", 32'h0, rdata);
      end_test();

      begin_test("start before init");
      start_block(22'h00_0400, len_t2, pat_addr, 32'h0);
      cmd_idle = 1'b1;
      repeat (10) begin
         @(negedge core_clk);
         cmd_idle &= (ddr2_cmd == cmd_nop);
      end
      check_flag("command stays nop before init", cmd_idle);
      host_read(reg_status, rdata);
      check_reg("status while waiting for init", 32'h1, rdata);
      model_setup(1'b1, 0, 1'b0, '0, 0);
      check_results(22'h00_0400, len_t2, -1, 0);
      end_test();

      begin_test("address pattern");
      start_block(22'h00_0100, len_t3, pat_addr, 32'h0);
      check_flag("write mask all zeros", ddr2_wr_data_mask == '0);
      check_results(22'h00_0100, len_t3, -1, 0);
      end_test();

      begin_test("seed pattern with fault");
      // bit 37 of the word at base plus 13 is stored inverted
      model_setup(1'b1, 0, 1'b1, 22'h00_200d, 37);
      start_block(22'h00_2000, len_t4, pat_seed, 32'h5a3c_e1f7);
      check_results(22'h00_2000, len_t4, 13, 37);
      end_test();

      begin_test("long run with refresh");
      model_setup(1'b1, 24, 1'b0, '0, 0);
      start_block(22'h01_0000, len_t5, pat_seed, 32'h0f1e_2d3c);
      check_results(22'h01_0000, len_t5, -1, 0);
      check_flag("refresh taken between bursts", ref_seen > 0);
      check_flag("no controller protocol violation", !violation);
      check_flag("bursts within burst_max words", max_burst <= burst_max);
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_cnt, fail_cnt, check_cnt, err_total);
      if (err_total == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: verilog.f
rtl/ddr_test_pkg.sv
rtl/ddr_test_regs.sv
rtl/ddr_block_rw.sv
rtl/ddr_read_checker.sv
rtl/ddr_test_top.sv
test/ddr_ctrl_model.sv
test/tb_ddr_test_top.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0 -Wno-fatal
TOP      := tb_ddr_test_top
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
